// ==== texture_pkg.sv ====
package texture_pkg;

  // grayscale sample
  typedef logic [7:0] pixel_t;

  // one bit per direction, bit 0 is east
  typedef logic [7:0] code_t;

  // sum of a full window, also holds 25 times one pixel
  typedef logic [12:0] win_sum_t;

  // window side and pixel count
  localparam int WIN      = 5;
  localparam int WIN_AREA = WIN * WIN;

  // sampling directions, counter-clockwise from east
  typedef enum logic [2:0] {
    DIR_E  = 3'd0,
    DIR_NE = 3'd1,
    DIR_N  = 3'd2,
    DIR_NW = 3'd3,
    DIR_W  = 3'd4,
    DIR_SW = 3'd5,
    DIR_S  = 3'd6,
    DIR_SE = 3'd7
  } dir_e;

endpackage

// ==== window_if.sv ====
`timescale 1ns/1ps

interface window_if;
  import texture_pkg::*;

  // px[0] is the oldest row, px[r][0] the oldest column
  pixel_t px [WIN][WIN];

  // one-cycle pulse for a complete interior window
  logic win_valid;
  // window completed by the last pixel of the frame
  logic win_last;

  modport src (
    output px,
    output win_valid,
    output win_last
  );

  modport dst (
    input px,
    input win_valid,
    input win_last
  );

endinterface

// ==== ring_if.sv ====
`timescale 1ns/1ps

interface ring_if;
  import texture_pkg::*;

  // radius-1 and radius-2 samples, indexed by direction
  pixel_t   inner [DIR_E:DIR_SE];
  pixel_t   outer [DIR_E:DIR_SE];
  // sum of all window pixels
  win_sum_t sum;

  logic ring_valid;
  logic ring_last;

  modport src (
    output inner,
    output outer,
    output sum,
    output ring_valid,
    output ring_last
  );

  modport dst (
    input inner,
    input outer,
    input sum,
    input ring_valid,
    input ring_last
  );

endinterface

// ==== line_buffer.sv ====
`timescale 1ns/1ps

module line_buffer #(
  parameter int ROWS = 30,
  parameter int COLS = 30
) (
  input  logic                clk,
  input  logic                rst_n_i,
  input  texture_pkg::pixel_t pixel_i,
  input  logic                pixel_valid_i,
  window_if.src               win
);
  import texture_pkg::*;

  localparam int ROW_W = $clog2(ROWS);
  localparam int COL_W = $clog2(COLS);

  // four previous rows, entry 0 holds the oldest
  pixel_t           line_mem [WIN-1][COLS];
  // new window column, top to bottom
  pixel_t           col_px   [WIN];
  logic [ROW_W-1:0] row_cnt;
  logic [COL_W-1:0] col_cnt;
  logic             col_end;
  logic             row_end;

  assign col_end = (col_cnt == COL_W'(COLS - 1));
  assign row_end = (row_cnt == ROW_W'(ROWS - 1));

  always_comb begin
    for (int r = 0; r < WIN - 1; r++) begin
      col_px[r] = line_mem[r][col_cnt];
    end
    col_px[WIN-1] = pixel_i;
  end

  // each row moves up one memory at the current column
  always_ff @(posedge clk) begin
    if (pixel_valid_i) begin
      for (int r = 0; r < WIN - 1; r++) begin
        line_mem[r][col_cnt] <= col_px[r+1];
      end
    end
  end

  // window shifts left, new column enters on the right
  always_ff @(posedge clk) begin
    if (pixel_valid_i) begin
      for (int r = 0; r < WIN; r++) begin
        for (int c = 0; c < WIN - 1; c++) begin
          win.px[r][c] <= win.px[r][c+1];
        end
        win.px[r][WIN-1] <= col_px[r];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      row_cnt       <= '0;
      col_cnt       <= '0;
      win.win_valid <= 1'b0;
      win.win_last  <= 1'b0;
    end else begin
      // counts still refer to the pixel accepted on this edge
      win.win_valid <= pixel_valid_i && (row_cnt >= ROW_W'(WIN - 1))
                       && (col_cnt >= COL_W'(WIN - 1));
      win.win_last  <= pixel_valid_i && row_end && col_end;
      if (pixel_valid_i) begin
        if (col_end) begin
          col_cnt <= '0;
          row_cnt <= row_end ? '0 : row_cnt + 1'b1;
        end else begin
          col_cnt <= col_cnt + 1'b1;
        end
      end
    end
  end

endmodule

// ==== ring_sampler.sv ====
`timescale 1ns/1ps

module ring_sampler (
  input  logic  clk,
  input  logic  rst_n_i,
  window_if.dst win,
  ring_if.src   ring
);
  import texture_pkg::*;

  localparam int CTR = WIN / 2;

  pixel_t   inner_c [DIR_E:DIR_SE];
  pixel_t   outer_c [DIR_E:DIR_SE];
  win_sum_t sum_c;

  // unit step per direction, north is the older row
  function automatic int row_step(dir_e d);
    case (d)
      DIR_NE, DIR_N, DIR_NW: row_step = -1;
      DIR_SW, DIR_S, DIR_SE: row_step = 1;
      default:               row_step = 0;
    endcase
  endfunction

  function automatic int col_step(dir_e d);
    case (d)
      DIR_E, DIR_NE, DIR_SE: col_step = 1;
      DIR_NW, DIR_W, DIR_SW: col_step = -1;
      default:               col_step = 0;
    endcase
  endfunction

  always_comb begin
    for (int d = DIR_E; d <= DIR_SE; d++) begin
      inner_c[d] = win.px[CTR + row_step(dir_e'(d))][CTR + col_step(dir_e'(d))];
      outer_c[d] = win.px[CTR + 2 * row_step(dir_e'(d))][CTR + 2 * col_step(dir_e'(d))];
    end
  end

  always_comb begin
    sum_c = '0;
    for (int r = 0; r < WIN; r++) begin
      for (int c = 0; c < WIN; c++) begin
        sum_c = sum_c + win_sum_t'(win.px[r][c]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (win.win_valid) begin
      ring.inner <= inner_c;
      ring.outer <= outer_c;
      ring.sum   <= sum_c;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ring.ring_valid <= 1'b0;
      ring.ring_last  <= 1'b0;
    end else begin
      ring.ring_valid <= win.win_valid;
      ring.ring_last  <= win.win_last;
    end
  end

endmodule

// ==== texture_codes.sv ====
`timescale 1ns/1ps

module texture_codes (
  input  logic               clk,
  input  logic               rst_n_i,
  ring_if.dst                ring,
  output texture_pkg::code_t rd_code_o,
  output texture_pkg::code_t ni_code_o,
  output logic               pattern_valid_o,
  output logic               frame_done_o
);
  import texture_pkg::*;

  code_t rd_c;
  code_t ni_c;

  always_comb begin
    for (int d = DIR_E; d <= DIR_SE; d++) begin
      rd_c[d] = (ring.outer[d] >= ring.inner[d]);
      // outer against the window mean, scaled up instead of divided
      ni_c[d] = (win_sum_t'(ring.outer[d]) * win_sum_t'(WIN_AREA) >= ring.sum);
    end
  end

  always_ff @(posedge clk) begin
    if (ring.ring_valid) begin
      rd_code_o <= rd_c;
      ni_code_o <= ni_c;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pattern_valid_o <= 1'b0;
      frame_done_o    <= 1'b0;
    end else begin
      pattern_valid_o <= ring.ring_valid;
      frame_done_o    <= ring.ring_last;
    end
  end

endmodule

// ==== texture_descriptor_top.sv ====
`timescale 1ns/1ps

module texture_descriptor_top #(
  parameter int ROWS = 30,
  parameter int COLS = 30
) (
  input  logic                clk,
  input  logic                rst_n_i,
  input  texture_pkg::pixel_t pixel_i,
  input  logic                pixel_valid_i,
  output texture_pkg::code_t  rd_code_o,
  output texture_pkg::code_t  ni_code_o,
  output logic                pattern_valid_o,
  output logic                frame_done_o
);

  window_if win_bus ();
  ring_if   ring_bus ();

  line_buffer #(
    .ROWS(ROWS),
    .COLS(COLS)
  ) line_buffer_inst (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .pixel_i      (pixel_i),
    .pixel_valid_i(pixel_valid_i),
    .win          (win_bus.src)
  );

  ring_sampler ring_sampler_inst (
    .clk    (clk),
    .rst_n_i(rst_n_i),
    .win    (win_bus.dst),
    .ring   (ring_bus.src)
  );

  texture_codes texture_codes_inst (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .ring           (ring_bus.dst),
    .rd_code_o      (rd_code_o),
    .ni_code_o      (ni_code_o),
    .pattern_valid_o(pattern_valid_o),
    .frame_done_o   (frame_done_o)
  );

endmodule

// ==== texture_chk.sv ====
`timescale 1ns/1ps

module texture_chk (
  input logic               clk,
  input logic               rst_n_i,
  input texture_pkg::code_t rd_code_o,
  input texture_pkg::code_t ni_code_o,
  input logic               pattern_valid_o,
  input logic               frame_done_o
);

  // the end of a frame comes with its last code
  done_with_code: assert property (@(posedge clk) disable iff (!rst_n_i)
    frame_done_o |-> pattern_valid_o)
    else $error("frame_done_o high without pattern_valid_o");

  quiet_in_reset: assert property (@(posedge clk)
    !rst_n_i |-> !pattern_valid_o && !frame_done_o)
    else $error("output pulse high while reset is asserted");

  known_codes: assert property (@(posedge clk) disable iff (!rst_n_i)
    pattern_valid_o |-> !$isunknown({rd_code_o, ni_code_o}))
    else $error("rd_code_o or ni_code_o unknown on a valid code");

endmodule

bind texture_descriptor_top texture_chk texture_chk_inst (
  .clk            (clk),
  .rst_n_i        (rst_n_i),
  .rd_code_o      (rd_code_o),
  .ni_code_o      (ni_code_o),
  .pattern_valid_o(pattern_valid_o),
  .frame_done_o   (frame_done_o)
);

// ==== tb_texture.sv ====
`timescale 1ns/1ps

module tb_texture;
  import texture_pkg::*;

  localparam int ROWS = 8;
  localparam int COLS = 8;
  localparam logic [31:0] SEED = 32'hb807_6b31;

  logic   clk;
  logic   rst_n_i;
  pixel_t pixel_i;
  logic   pixel_valid_i;
  code_t  rd_code_o;
  code_t  ni_code_o;
  logic   pattern_valid_o;
  logic   frame_done_o;

  pixel_t      frame [ROWS][COLS];
  logic [31:0] lfsr;
  code_t       exp_rd [$];
  code_t       exp_ni [$];
  logic        exp_last [$];
  int          c_id [$];
  int          c_kind [$];
  int          c_base [$];
  int          c_gap [$];
  int          c_count [$];
  int          err_cnt;
  int          codes_seen;
  int          done_seen;
  int          cycles;
  int          cycle_limit;

  // unit offsets per direction, north is one row up
  int dr [DIR_E:DIR_SE] = '{0, -1, -1, -1, 0, 1, 1, 1};
  int dc [DIR_E:DIR_SE] = '{1, 1, 0, -1, -1, -1, 0, 1};

  texture_descriptor_top #(
    .ROWS(ROWS),
    .COLS(COLS)
  ) texture_descriptor_top_inst (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .pixel_i        (pixel_i),
    .pixel_valid_i  (pixel_valid_i),
    .rd_code_o      (rd_code_o),
    .ni_code_o      (ni_code_o),
    .pattern_valid_o(pattern_valid_o),
    .frame_done_o   (frame_done_o)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr[0]);
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic check_code(string name, code_t exp, code_t act);
    if (act !== exp) begin
      $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("ERR t=%0t %s expected %b got %b", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_count(string name, int exp, int act);
    if (act != exp) begin
      $display("ERR t=%0t %s expected %0d got %0d", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic build_frame(int kind, int base);
    int v;
    // same base gives the same random frame
    if (kind == 3) begin
      lfsr = SEED ^ 32'(base);
    end
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        case (kind)
          0:       v = base;
          1:       v = base + 9 * c;
          2:       v = base + 11 * r;
          default: take_bits(8, v);
        endcase
        frame[r][c] = pixel_t'(v);
      end
    end
  endtask

  // reference codes for every interior centre, row-major
  task automatic build_expected();
    int    sum;
    int    inner;
    int    outer;
    code_t rd;
    code_t ni;
    for (int r = 2; r < ROWS - 2; r++) begin
      for (int c = 2; c < COLS - 2; c++) begin
        sum = 0;
        for (int i = -2; i <= 2; i++) begin
          for (int j = -2; j <= 2; j++) begin
            sum += int'(frame[r+i][c+j]);
          end
        end
        for (int d = DIR_E; d <= DIR_SE; d++) begin
          inner = int'(frame[r+dr[d]][c+dc[d]]);
          outer = int'(frame[r+2*dr[d]][c+2*dc[d]]);
          rd[d] = (outer >= inner);
          ni[d] = (outer * WIN_AREA >= sum);
        end
        exp_rd.push_back(rd);
        exp_ni.push_back(ni);
        exp_last.push_back(r == ROWS - 3 && c == COLS - 3);
      end
    end
  endtask

  task automatic drive_frame(int gap, int npix);
    int idle;
    for (int k = 0; k < npix; k++) begin
      idle = 0;
      if (gap == 1) begin
        take_bits(1, idle);
      end
      if (idle != 0) begin
        @(negedge clk);
        pixel_valid_i = 1'b0;
      end
      @(negedge clk);
      pixel_i       = frame[k / COLS][k % COLS];
      pixel_valid_i = 1'b1;
    end
    @(negedge clk);
    pixel_valid_i = 1'b0;
  endtask

  task automatic apply_reset();
    rst_n_i       = 1'b0;
    pixel_valid_i = 1'b0;
    repeat (2) @(negedge clk);
    rst_n_i = 1'b1;
  endtask

  always @(negedge clk) begin
    if (pattern_valid_o) begin
      if (exp_rd.size() == 0) begin
        $display("code at t=%0t arrived with no expected code left", $time);
        err_cnt++;
      end else begin
        check_code("rd_code_o", exp_rd.pop_front(), rd_code_o);
        check_code("ni_code_o", exp_ni.pop_front(), ni_code_o);
        check_flag("frame_done_o", exp_last.pop_front(), frame_done_o);
      end
      codes_seen++;
    end
    if (frame_done_o) begin
      done_seen++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the pipeline never drained", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    int    fd;
    int    n;
    string line;
    int    id;
    int    kind;
    int    base;
    int    gap;
    int    count;
    int    errs_before;
    int    passed;
    int    failed;
    clk           = 1'b0;
    rst_n_i       = 1'b0;
    pixel_i       = '0;
    pixel_valid_i = 1'b0;
    lfsr          = SEED;
    err_cnt       = 0;
    cycles        = 0;
    cycle_limit   = 0;
    passed        = 0;
    failed        = 0;
    fd = $fopen("texture_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open texture_cases.txt");
      err_cnt++;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 1 && line[0] != "#") begin
          if ($sscanf(line, "%d %d %h %d %d", id, kind, base, gap, count) == 5) begin
            c_id.push_back(id);
            c_kind.push_back(kind);
            c_base.push_back(base);
            c_gap.push_back(gap);
            c_count.push_back(count);
          end
        end
      end
      $fclose(fd);
    end
    cycle_limit = c_id.size() * (2 * ROWS * COLS + 20);
    apply_reset();
    for (int k = 0; k < c_id.size(); k++) begin
      errs_before = err_cnt;
      codes_seen  = 0;
      done_seen   = 0;
      build_frame(c_kind[k], c_base[k]);
      // partial frame, then reset drops it
      if (c_gap[k] == 2) begin
        drive_frame(0, 29);
        apply_reset();
      end
      build_expected();
      drive_frame(c_gap[k], ROWS * COLS);
      while (exp_rd.size() != 0) begin
        @(negedge clk);
      end
      repeat (3) @(negedge clk);
      check_count("code count", c_count[k], codes_seen);
      check_count("frame_done_o pulses", 1, done_seen);
      if (err_cnt == errs_before) begin
        passed++;
      end else begin
        failed++;
      end
      $display("case %0d kind %0d base %0d gap %0d: %0d codes, %s", c_id[k], c_kind[k],
               c_base[k], c_gap[k], codes_seen, (err_cnt == errs_before) ? "ok" : "failed");
    end
    $display("cases %0d passed %0d failed %0d errors %0d", c_id.size(), passed, failed,
             err_cnt);
    if (err_cnt == 0 && failed == 0 && c_id.size() > 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== texture_cases.txt ====
# id kind base(hex) gap count
# kind 0 flat, 1 column ramp, 2 row ramp, 3 lfsr; gap 0 none, 1 idle cycles, 2 reset mid-frame
1 0 50 0 16
2 0 ff 0 16
3 0 00 0 16
4 1 0a 0 16
5 1 f0 0 16
6 2 20 0 16
7 2 c8 1 16
8 3 00 0 16
9 3 00 1 16
10 3 5a 0 16
11 3 5a 2 16
12 1 33 2 16
13 3 c3 1 16

// ==== sim.f ====
texture_pkg.sv
window_if.sv
ring_if.sv
line_buffer.sv
ring_sampler.sv
texture_codes.sv
texture_descriptor_top.sv
texture_chk.sv
tb_texture.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_texture
RTL_TOP   ?= texture_descriptor_top
FLIST     ?= sim.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
BIN       ?= sim_bin
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -Wno-fatal -f $(FLIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(BIN)
	./$(OBJ_DIR)/$(BIN) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
